/* design/vst_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths, element width encoding and channel structs of the vector
// store path. Modules import it inside their bodies as needed.
////////////////////////////////////////////////////////////////////////////

package vst_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Byte address width on the AW channel
  localparam int unsigned AddrWidth = 32;
  // One lane operand word
  localparam int unsigned ElenBits  = 64;
  // Instruction id and vector length
  localparam int unsigned IdWidth   = 3;
  localparam int unsigned VlWidth   = 12;

  // Element width, the byte count is 1 << encoding
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Byte count of a whole instruction, vl times up to 8 bytes
  typedef logic [VlWidth+2:0] bytes_t;

  ////////////////////////////////////////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////////////////////////////////////////

  // One store instruction from the sequencer
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [VlWidth-1:0]   vl;
    eew_e                 eew;
    // Set means the mask is ignored
    logic                 vm;
  } st_req_t;

  // One incrementing burst, len is beats minus 1
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
  } aw_req_t;

  // Burst shape handed to the beat packer
  typedef struct packed {
    logic [8:0] beats;
    bytes_t     bytes;
    eew_e       eew;
    // Strobes need the mask-disable flag too
    logic       vm;
  } burst_desc_t;

  // Bytes in one element
  function automatic logic [3:0] eew_bytes(eew_e eew);
    return 4'd1 << eew;
  endfunction

  // Beats in the burst, rounded up to whole beats
  function automatic logic [8:0] burst_beats(logic [VlWidth-1:0] vl, eew_e eew,
                                             int unsigned beat_bytes);
    bytes_t      total;
    int unsigned nbeats;
    total  = bytes_t'(vl) << eew;
    nbeats = (int'(total) + beat_bytes - 1) / beat_bytes;
    return 9'(nbeats);
  endfunction

endpackage

/* design/vst_insn_queue.sv */
////////////////////////////////////////////////////////////////////////////
// Store instruction queue. Accepts requests from the sequencer, hands them
// to the address generator in order and retires them on B responses.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vst_insn_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Sequencer requests
  input  vst_pkg::st_req_t             req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  // Oldest request not yet issued
  output vst_pkg::st_req_t             issue_req_o,
  output logic                         issue_valid_o,
  input  logic                         issue_ready_i,
  // AW handshake seen by the address generator
  input  logic                         aw_done_i,
  // Memory write response
  input  logic                         b_valid_i,
  output logic                         b_ready_o,
  // Retirement report
  output logic                         done_o,
  output logic [vst_pkg::IdWidth-1:0]  done_id_o,
  output logic                         pending_o
);

  import vst_pkg::*;

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  typedef logic [PtrWidth-1:0] pnt_t;
  typedef logic [CntWidth-1:0] cnt_t;

  // Pointers for the accept, issue and commit phases
  typedef struct packed {
    pnt_t accept_pnt;
    pnt_t issue_pnt;
    pnt_t commit_pnt;
    // Entries waiting for issue, entries held overall
    cnt_t issue_cnt;
    cnt_t commit_cnt;
    // Bursts on AW still waiting for B
    cnt_t burst_cnt;
  } ctrl_t;

  ctrl_t   ctrl_d, ctrl_q;
  st_req_t queue_q [QueueDepth];
  logic    done_q;
  logic    accept, issue, b_hs;

  // Wraps at QueueDepth so odd depths work too
  function automatic pnt_t next_pnt(pnt_t pnt);
    return (pnt == pnt_t'(QueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign req_ready_o   = (ctrl_q.commit_cnt != cnt_t'(QueueDepth));
  assign issue_valid_o = (ctrl_q.issue_cnt != '0);
  assign issue_req_o   = queue_q[ctrl_q.issue_pnt];
  assign b_ready_o     = (ctrl_q.burst_cnt != '0);

  assign accept = req_valid_i && req_ready_o;
  assign issue  = issue_valid_o && issue_ready_i;
  assign b_hs   = b_valid_i && b_ready_o;

  // Held until the done pulse has gone out
  assign pending_o = (ctrl_q.commit_cnt != '0) || done_q;
  assign done_o    = done_q;

  always_comb begin
    ctrl_d = ctrl_q;
    if (accept) ctrl_d.accept_pnt = next_pnt(ctrl_q.accept_pnt);
    if (issue) ctrl_d.issue_pnt = next_pnt(ctrl_q.issue_pnt);
    if (b_hs) ctrl_d.commit_pnt = next_pnt(ctrl_q.commit_pnt);
    // Up and down in one cycle cancel out
    ctrl_d.issue_cnt  = ctrl_q.issue_cnt + cnt_t'(accept) - cnt_t'(issue);
    ctrl_d.commit_cnt = ctrl_q.commit_cnt + cnt_t'(accept) - cnt_t'(b_hs);
    ctrl_d.burst_cnt  = ctrl_q.burst_cnt + cnt_t'(aw_done_i) - cnt_t'(b_hs);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
      done_q <= 1'b0;
    end else begin
      ctrl_q <= ctrl_d;
      // One-cycle pulse after the B handshake
      done_q <= b_hs;
    end
  end

  // Entry storage and the reported id
  always_ff @(posedge clk_i) begin
    if (accept) queue_q[ctrl_q.accept_pnt] <= req_i;
    if (b_hs) done_id_o <= queue_q[ctrl_q.commit_pnt].id;
  end

endmodule

/* design/vst_addrgen.sv */
////////////////////////////////////////////////////////////////////////////
// Address generator. Turns one issued store into a single AW burst and a
// burst descriptor, and takes the next store once both have been taken.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vst_addrgen #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Issued instruction from the queue
  input  vst_pkg::st_req_t      issue_req_i,
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  // AW channel
  output vst_pkg::aw_req_t      aw_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output logic                  aw_done_o,
  // Descriptor for the beat packer
  output vst_pkg::burst_desc_t  desc_o,
  output logic                  desc_valid_o,
  input  logic                  desc_ready_i
);

  import vst_pkg::*;

  // One beat carries one full VRF word
  localparam int unsigned BeatBytes = NrLanes * 8;

  aw_req_t     aw_q;
  burst_desc_t desc_q;
  logic        aw_valid_q, desc_valid_q;
  logic [8:0]  issue_beats;
  bytes_t      issue_bytes;
  logic        issue;

  // Idle only when both sides of the last burst are gone
  assign issue_ready_o = !aw_valid_q && !desc_valid_q;
  assign issue         = issue_valid_i && issue_ready_o;

  // Burst shape of the incoming store
  assign issue_beats = burst_beats(issue_req_i.vl, issue_req_i.eew, BeatBytes);
  assign issue_bytes = bytes_t'(issue_req_i.vl) << issue_req_i.eew;

  assign aw_o         = aw_q;
  assign aw_valid_o   = aw_valid_q;
  assign aw_done_o    = aw_valid_q && aw_ready_i;
  assign desc_o       = desc_q;
  assign desc_valid_o = desc_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_valid_q   <= 1'b0;
      desc_valid_q <= 1'b0;
    end else begin
      if (issue) begin
        aw_valid_q   <= 1'b1;
        desc_valid_q <= 1'b1;
      end else begin
        if (aw_done_o) aw_valid_q <= 1'b0;
        // Packer acks on its last W beat
        if (desc_valid_q && desc_ready_i) desc_valid_q <= 1'b0;
      end
    end
  end

  // Payloads load on issue and hold until taken
  always_ff @(posedge clk_i) begin
    if (issue) begin
      aw_q.addr    <= issue_req_i.addr;
      aw_q.len     <= 8'(issue_beats - 9'd1);
      desc_q.beats <= issue_beats;
      desc_q.bytes <= issue_bytes;
      desc_q.eew   <= issue_req_i.eew;
      desc_q.vm    <= issue_req_i.vm;
    end
  end

endmodule

/* design/vst_beat_packer.sv */
////////////////////////////////////////////////////////////////////////////
// W beat packer. Joins one word from every lane into a W beat, undoes the
// lane interleaving of elements and applies mask strobes per byte.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vst_beat_packer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Current burst
  input  vst_pkg::burst_desc_t                        desc_i,
  input  logic                                        desc_valid_i,
  output logic                                        desc_ready_o,
  // Lane operands
  input  logic [NrLanes-1:0][vst_pkg::ElenBits-1:0]   operand_i,
  input  logic [NrLanes-1:0]                          operand_valid_i,
  output logic                                        operand_ready_o,
  // Mask bytes, one bit per lane byte
  input  logic [NrLanes-1:0][7:0]                     mask_i,
  input  logic                                        mask_valid_i,
  output logic                                        mask_ready_o,
  // W channel
  output logic [NrLanes*vst_pkg::ElenBits-1:0]        w_data_o,
  output logic [NrLanes*8-1:0]                        w_strb_o,
  output logic                                        w_last_o,
  output logic                                        w_valid_o,
  input  logic                                        w_ready_i
);

  import vst_pkg::*;

  localparam int unsigned BeatBytes = NrLanes * 8;

  logic [8:0] beat_cnt_q;
  logic       w_hs;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  // All lanes present, mask too unless disabled
  assign w_valid_o = desc_valid_i && (&operand_valid_i) && (mask_valid_i || desc_i.vm);
  assign w_hs      = w_valid_o && w_ready_i;

  // Operands and mask retire with the beat
  assign operand_ready_o = w_hs;
  assign mask_ready_o    = w_hs && !desc_i.vm;

  assign w_last_o     = desc_valid_i && (beat_cnt_q == desc_i.beats - 9'd1);
  assign desc_ready_o = w_hs && w_last_o;

  ////////////////////////////////////////////////////////////////////////////
  // Byte shuffle and strobes
  ////////////////////////////////////////////////////////////////////////////

  // A beat spans whole element groups over all lanes, so only the
  // position inside the beat matters for the lane and lane byte
  always_comb begin
    w_data_o = '0;
    w_strb_o = '0;
    for (int unsigned j = 0; j < BeatBytes; j++) begin
      automatic int unsigned eb;
      automatic int unsigned elem;
      automatic int unsigned lane;
      automatic int unsigned offs;
      automatic int unsigned byte_idx;
      eb       = int'(eew_bytes(desc_i.eew));
      // Element within this beat
      elem     = j / eb;
      lane     = elem % NrLanes;
      // Row of the element in its lane, then byte within the element
      offs     = (elem / NrLanes) * eb + j % eb;
      // Byte index within the whole instruction
      byte_idx = int'(beat_cnt_q) * BeatBytes + j;
      w_data_o[8*j +: 8] = operand_i[lane][8*offs +: 8];
      // Tail bytes past vl never get a strobe
      w_strb_o[j] = (byte_idx < int'(desc_i.bytes)) && (desc_i.vm || mask_i[lane][offs]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (w_hs) begin
      // Restart for the next burst
      if (w_last_o) begin
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 9'd1;
      end
    end
  end

endmodule

/* design/vst_top.sv */
////////////////////////////////////////////////////////////////////////////
// Vector store path top level. Queue, address generator and beat packer
// between the sequencer, the lanes, the mask unit and memory.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vst_top #(
  parameter int unsigned NrLanes    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Sequencer
  input  vst_pkg::st_req_t                            req_i,
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  output logic                                        done_o,
  output logic [vst_pkg::IdWidth-1:0]                 done_id_o,
  output logic                                        pending_o,
  // Memory AW channel
  output vst_pkg::aw_req_t                            aw_o,
  output logic                                        aw_valid_o,
  input  logic                                        aw_ready_i,
  // Memory W channel
  output logic [NrLanes*vst_pkg::ElenBits-1:0]        w_data_o,
  output logic [NrLanes*8-1:0]                        w_strb_o,
  output logic                                        w_last_o,
  output logic                                        w_valid_o,
  input  logic                                        w_ready_i,
  // Memory B channel
  input  logic                                        b_valid_i,
  output logic                                        b_ready_o,
  // Lanes
  input  logic [NrLanes-1:0][vst_pkg::ElenBits-1:0]   operand_i,
  input  logic [NrLanes-1:0]                          operand_valid_i,
  output logic                                        operand_ready_o,
  // Mask unit
  input  logic [NrLanes-1:0][7:0]                     mask_i,
  input  logic                                        mask_valid_i,
  output logic                                        mask_ready_o
);

  import vst_pkg::*;

  // Queue to address generator
  st_req_t     issue_req;
  logic        issue_valid, issue_ready;
  // Address generator to queue and packer
  logic        aw_done;
  burst_desc_t desc;
  logic        desc_valid, desc_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction queue
  ////////////////////////////////////////////////////////////////////////////

  vst_insn_queue #(
    .QueueDepth(QueueDepth)
  ) i_insn_queue (
    .clk_i, .rst_ni,
    .req_i, .req_valid_i, .req_ready_o,
    .issue_req_o(issue_req), .issue_valid_o(issue_valid), .issue_ready_i(issue_ready),
    .aw_done_i(aw_done),
    .b_valid_i, .b_ready_o,
    .done_o, .done_id_o, .pending_o
  );

  // One burst per store
  vst_addrgen #(
    .NrLanes(NrLanes)
  ) i_addrgen (
    .clk_i, .rst_ni,
    .issue_req_i(issue_req), .issue_valid_i(issue_valid), .issue_ready_o(issue_ready),
    .aw_o, .aw_valid_o, .aw_ready_i, .aw_done_o(aw_done),
    .desc_o(desc), .desc_valid_o(desc_valid), .desc_ready_i(desc_ready)
  );

  // W beats from lane words
  vst_beat_packer #(
    .NrLanes(NrLanes)
  ) i_beat_packer (
    .clk_i, .rst_ni,
    .desc_i(desc), .desc_valid_i(desc_valid), .desc_ready_o(desc_ready),
    .operand_i, .operand_valid_i, .operand_ready_o,
    .mask_i, .mask_valid_i, .mask_ready_o,
    .w_data_o, .w_strb_o, .w_last_o, .w_valid_o, .w_ready_i
  );

endmodule

/* testbench/vst_properties.sv */
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the store path top level, bound into vst_top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vst_properties #(
  parameter int unsigned NrLanes    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input logic                                 clk_i,
  input logic                                 rst_ni,
  input logic                                 req_valid_i,
  input vst_pkg::aw_req_t                     aw_o,
  input logic                                 aw_valid_o,
  input logic                                 aw_ready_i,
  input logic [NrLanes*vst_pkg::ElenBits-1:0] w_data_o,
  input logic [NrLanes*8-1:0]                 w_strb_o,
  input logic                                 w_last_o,
  input logic                                 w_valid_o,
  input logic                                 w_ready_i,
  input logic                                 b_valid_i,
  input logic                                 b_ready_o,
  input logic                                 req_ready_o,
  input logic                                 done_o,
  input logic                                 pending_o
);

  // Stores taken from the sequencer and not yet answered on B
  int unsigned held_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 0;
    end else begin
      held_q <= held_q + (req_valid_i && req_ready_o) - (b_valid_i && b_ready_o);
    end
  end

  // A stalled AW keeps valid and payload
  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("AW payload changed while stalled");

  // Same for a stalled W beat
  w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o)
      && $stable(w_last_o))
    else $error("W beat changed while stalled");

  // A store still waiting for its done counts as pending
  held_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    held_q != 0 |-> pending_o)
    else $error("Store held while pending is low");

  // Empty queue always takes a request
  empty_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    held_q == 0 |-> req_ready_o)
    else $error("Request refused while the queue is empty");

  // Never more stores than queue entries
  held_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    held_q <= QueueDepth)
    else $error("More stores held than the queue has entries");

endmodule

bind vst_top vst_properties #(
  .NrLanes(NrLanes),
  .QueueDepth(QueueDepth)
) i_properties (
  .clk_i, .rst_ni,
  .req_valid_i,
  .aw_o, .aw_valid_o, .aw_ready_i,
  .w_data_o, .w_strb_o, .w_last_o, .w_valid_o, .w_ready_i,
  .b_valid_i, .b_ready_o,
  .req_ready_o, .done_o, .pending_o
);

/* testbench/vst_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the vector store path. Random stores and stalls from an
// LCG, a model that predicts AW, W and done, and a final verdict.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vst_tb;

  import vst_pkg::*;

  localparam int unsigned NrLanes       = 4;
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned BeatBytes     = NrLanes * 8;
  localparam int unsigned NumReqs       = 40;
  // Generous bound per store under random stalls
  localparam int unsigned TimeoutCycles = NumReqs * 300;

  // One W beat as seen on the bus
  typedef struct packed {
    logic [BeatBytes*8-1:0] data;
    logic [BeatBytes-1:0]   strb;
    logic                   last;
  } w_beat_t;

  // DUT ports
  logic                             clk_i, rst_ni;
  st_req_t                          req_i;
  logic                             req_valid_i, req_ready_o, done_o, pending_o;
  logic [IdWidth-1:0]               done_id_o;
  aw_req_t                          aw_o;
  logic                             aw_valid_o, aw_ready_i;
  logic [BeatBytes*8-1:0]           w_data_o;
  logic [BeatBytes-1:0]             w_strb_o;
  logic                             w_last_o, w_valid_o, w_ready_i;
  logic                             b_valid_i, b_ready_o;
  logic [NrLanes-1:0][ElenBits-1:0] operand_i;
  logic [NrLanes-1:0]               operand_valid_i;
  logic                             operand_ready_o;
  logic [NrLanes-1:0][7:0]          mask_i;
  logic                             mask_valid_i, mask_ready_o;

  // Model state, expected stores per channel in request order
  logic [31:0]        lcg_state;
  st_req_t            aw_exp[$], w_exp[$], done_exp[$];
  // Cycle at which each pending B may go out
  int unsigned        b_due[$];
  logic               id_busy [2**IdWidth];
  int unsigned        cycle, sent, done_cnt, w_beat;
  // Bursts past AW that memory has not answered yet
  int unsigned        aw_open;
  logic               req_hs, aw_hs, w_hs, b_hs, b_hs_q, mask_hs;
  logic [NrLanes-1:0] lane_hs;

  vst_top #(.NrLanes(NrLanes), .QueueDepth(QueueDepth)) dut (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits only, the low LCG bits repeat quickly
  function automatic int unsigned rand_below(int unsigned n);
    return (next_rand() >> 8) % n;
  endfunction

  function automatic logic [ElenBits-1:0] lane_word();
    logic [31:0] hi, lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  function automatic logic [NrLanes-1:0][7:0] new_mask();
    logic [NrLanes-1:0][7:0] m;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      m[l] = 8'(next_rand() >> 16);
    end
    return m;
  endfunction

  function automatic st_req_t new_request();
    st_req_t req;
    req.id = IdWidth'(rand_below(2**IdWidth));
    // Skip ids whose store has not retired yet
    while (id_busy[req.id]) req.id = req.id + 1'b1;
    req.addr = next_rand() & ~(AddrWidth'(BeatBytes) - 1'b1);
    req.vl   = VlWidth'(1 + rand_below(64));
    req.eew  = eew_e'(rand_below(4));
    req.vm   = rand_below(2) == 1;
    return req;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////////////////////

  // One burst at the base address, beats rounded up
  function automatic aw_req_t expect_aw(st_req_t req);
    aw_req_t     exp;
    int unsigned total;
    total    = req.vl * (32'd1 << req.eew);
    exp.addr = req.addr;
    exp.len  = 8'((total + BeatBytes - 1) / BeatBytes - 1);
    return exp;
  endfunction

  // Walks every lane byte and places it at its memory byte in the beat
  function automatic w_beat_t expect_beat(st_req_t req, int unsigned beat,
                                          logic [NrLanes-1:0][ElenBits-1:0] lanes,
                                          logic [NrLanes-1:0][7:0] mask);
    w_beat_t     exp;
    int unsigned eb, total, nbeats, elem, pos;
    eb     = 32'd1 << req.eew;
    total  = req.vl * eb;
    nbeats = (total + BeatBytes - 1) / BeatBytes;
    exp    = '0;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      for (int unsigned k = 0; k < 8; k++) begin
        // Lane byte k is byte k % eb of row k / eb in this lane
        elem = (k / eb) * NrLanes + l;
        pos  = elem * eb + k % eb;
        exp.data[8*pos +: 8] = lanes[l][8*k +: 8];
        exp.strb[pos] = (beat * BeatBytes + pos < total) && (req.vm || mask[l][k]);
      end
    end
    exp.last = (beat == nbeats - 1);
    return exp;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare_aw(aw_req_t got, aw_req_t exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH aw_o: got addr %h len %h, expected addr %h len %h",
                         got.addr, got.len, exp.addr, exp.len));
    end
  endtask

  // Data only counts where the strobe is expected
  task automatic compare_beat(w_beat_t got, w_beat_t exp);
    logic [BeatBytes*8-1:0] keep;
    for (int unsigned j = 0; j < BeatBytes; j++) begin
      keep[8*j +: 8] = {8{exp.strb[j]}};
    end
    if (((got.data ^ exp.data) & keep) !== '0 || got.strb !== exp.strb ||
        got.last !== exp.last) begin
      stop_run($sformatf("MISMATCH w_data_o/w_strb_o/w_last_o: got %h/%h/%h, expected %h/%h/%h",
                         got.data, got.strb, got.last, exp.data & keep, exp.strb, exp.last));
    end
  endtask

  task automatic compare_id(logic [IdWidth-1:0] got, logic [IdWidth-1:0] exp);
    if (got !== exp) stop_run($sformatf("MISMATCH done_id_o: got %h, expected %h", got, exp));
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) stop_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle drive and observe
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle();
    cycle++;
    if (cycle > TimeoutCycles) begin
      stop_run($sformatf("Timeout after %0d cycles with %0d of %0d stores done",
                         TimeoutCycles, done_cnt, NumReqs));
    end
    // Sequencer holds a request until it is taken
    if (req_hs) req_valid_i = 1'b0;
    if (!req_valid_i && sent < NumReqs && rand_below(3) != 0) begin
      req_i = new_request();
      id_busy[req_i.id] = 1'b1;
      req_valid_i = 1'b1;
      sent++;
    end
    // Lanes refill after each beat and raise valid at random
    for (int unsigned l = 0; l < NrLanes; l++) begin
      if (lane_hs[l]) begin
        operand_valid_i[l] = 1'b0;
        operand_i[l] = lane_word();
      end
      if (!operand_valid_i[l] && rand_below(4) != 0) operand_valid_i[l] = 1'b1;
    end
    if (mask_hs) mask_i = new_mask();
    aw_ready_i = rand_below(4) != 0;
    w_ready_i  = rand_below(4) != 0;
    b_valid_i  = b_due.size() != 0 && cycle >= b_due[0];
  endtask

  // Runs mid-cycle, sees what the next rising edge will take
  task automatic observe_cycle();
    w_beat_t     exp;
    int unsigned due;
    // Memory may answer once the burst's AW has gone out
    compare_flag("b_ready_o", b_ready_o, aw_open != 0);
    req_hs  = req_valid_i && req_ready_o;
    aw_hs   = aw_valid_o && aw_ready_i;
    w_hs    = w_valid_o && w_ready_i;
    b_hs    = b_valid_i && b_ready_o;
    mask_hs = mask_valid_i && mask_ready_o;
    lane_hs = operand_valid_i & {NrLanes{operand_ready_o}};
    if (req_hs) begin
      aw_exp.push_back(req_i);
      w_exp.push_back(req_i);
      done_exp.push_back(req_i);
    end
    if (aw_hs) begin
      if (aw_exp.size() == 0) stop_run("AW burst issued with no store waiting for it");
      compare_aw(aw_o, expect_aw(aw_exp.pop_front()));
    end
    // Lane words and mask bytes are taken with the beat
    compare_flag("operand_ready_o", operand_ready_o, w_hs);
    if (!w_hs) compare_flag("mask_ready_o", mask_ready_o, 1'b0);
    if (w_hs) begin
      if (w_exp.size() == 0) stop_run("W beat sent with no store waiting for it");
      compare_flag("mask_ready_o", mask_ready_o, !w_exp[0].vm);
      exp = expect_beat(w_exp[0], w_beat, operand_i, mask_i);
      compare_beat({w_data_o, w_strb_o, w_last_o}, exp);
      if (exp.last) begin
        void'(w_exp.pop_front());
        w_beat = 0;
        // Memory answers 0 to 5 cycles later, in order
        due = cycle + 1 + rand_below(6);
        if (b_due.size() != 0 && due < b_due[$]) due = b_due[$];
        b_due.push_back(due);
      end else begin
        w_beat++;
      end
    end
    // Each B retires exactly one store on the next cycle
    compare_flag("done_o", done_o, b_hs_q);
    if (done_o) begin
      compare_id(done_id_o, done_exp[0].id);
      id_busy[done_exp[0].id] = 1'b0;
      void'(done_exp.pop_front());
      done_cnt++;
    end
    if (b_hs) void'(b_due.pop_front());
    aw_open = aw_open + aw_hs - b_hs;
    b_hs_q  = b_hs;
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    lcg_state       = 32'h428d;
    req_i           = '0;
    req_valid_i     = 1'b0;
    aw_ready_i      = 1'b0;
    w_ready_i       = 1'b0;
    b_valid_i       = 1'b0;
    operand_valid_i = '0;
    mask_valid_i    = 1'b0;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      operand_i[l] = lane_word();
    end
    mask_i = new_mask();
    foreach (id_busy[i]) id_busy[i] = 1'b0;
    {cycle, sent, done_cnt, w_beat, aw_open} = '0;
    {req_hs, aw_hs, w_hs, b_hs, b_hs_q, mask_hs} = '0;
    lane_hs = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni       = 1'b1;
    mask_valid_i = 1'b1;
    @(negedge clk_i);
    compare_flag("w_valid_o", w_valid_o, 1'b0);
    compare_flag("aw_valid_o", aw_valid_o, 1'b0);
    compare_flag("done_o", done_o, 1'b0);
    compare_flag("pending_o", pending_o, 1'b0);
    compare_flag("req_ready_o", req_ready_o, 1'b1);
    while (done_cnt < NumReqs) begin
      @(posedge clk_i);
      #1;
      drive_cycle();
      @(negedge clk_i);
      observe_cycle();
    end
    // One more cycle so the last done pulse clears
    @(posedge clk_i);
    #1;
    drive_cycle();
    @(negedge clk_i);
    observe_cycle();
    compare_flag("pending_o", pending_o, 1'b0);
    if (aw_exp.size() != 0 || w_exp.size() != 0 || b_due.size() != 0) begin
      stop_run("Stores left without their AW burst, W beats or B response");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

/* filelist.f */
design/vst_pkg.sv
design/vst_insn_queue.sv
design/vst_addrgen.sv
design/vst_beat_packer.sv
design/vst_top.sv
testbench/vst_properties.sv
testbench/vst_tb.sv

/* Makefile */
# Verilator build and run of the vector store path testbench

SIM := obj_dir/Vvst_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module vst_tb -f filelist.f

run: compile
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir $(LOG)
